// ==== alu.sv ====
`timescale 1ns/1ps
`include "datapath_consts.svh"

module alu (
   input  logic                     Clock,
   input  logic                     reset,
   input  isaPkg::aluOp_e           op,
   input  logic [`WORD_WIDTH-1:0]   a,
   input  logic [`WORD_WIDTH-1:0]   b,
   input  logic                     start,
   output logic [2*`WORD_WIDTH-1:0] result,
   output logic                     finished
);

   localparam int CountWidth = $clog2(`MUL_CYCLES);
   localparam logic [CountWidth-1:0] LastStep = CountWidth'(`MUL_CYCLES - 1);

   logic [2*`WORD_WIDTH-1:0] acc;
   logic [2*`WORD_WIDTH-1:0] mcand;     // shifts left each step
   logic [`WORD_WIDTH-1:0]   mplier;    // shifts right, bit 0 picks the add
   logic [2*`WORD_WIDTH-1:0] accNext;
   logic [CountWidth-1:0]    count;
   logic                     running;

   assign accNext  = mplier[0] ? acc + mcand : acc;
   assign finished = running && count == LastStep;   // last step lands this cycle

   always_ff @(posedge Clock) begin
      if (reset) begin
         running <= 1'b0;
         count   <= '0;
      end else if (start) begin
         running <= 1'b1;
         count   <= '0;
      end else if (running) begin
         count <= count + CountWidth'(1);
         if (finished)
            running <= 1'b0;
      end
   end

   always_ff @(posedge Clock) begin
      if (start) begin
         acc    <= '0;
         mcand  <= {{`WORD_WIDTH{1'b0}}, a};
         mplier <= b;
      end else if (running) begin
         acc    <= accNext;
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   always_comb begin
      case (op)
         isaPkg::ALU_ADD: result = {{`WORD_WIDTH{1'b0}}, a + b};
         isaPkg::ALU_SUB: result = {{`WORD_WIDTH{1'b0}}, a - b};
         isaPkg::ALU_AND: result = {{`WORD_WIDTH{1'b0}}, a & b};
         isaPkg::ALU_OR:  result = {{`WORD_WIDTH{1'b0}}, a | b};
         isaPkg::ALU_NOT: result = {{`WORD_WIDTH{1'b0}}, ~a};
         isaPkg::ALU_NEG: result = {{`WORD_WIDTH{1'b0}}, -a};
         isaPkg::ALU_MUL: result = accNext;   // full product on finished
         default:         result = '0;
      endcase
   end

endmodule

// ==== busDatapath.sv ====
`timescale 1ns/1ps
`include "datapath_consts.svh"

module busDatapath (
   input  logic                   Clock,
   input  logic                   reset,
   input  busPkg::controlWord_t   ctrl,
   input  logic [`WORD_WIDTH-1:0] dataIn,
   input  isaPkg::instr_t         instr,
   output logic [`WORD_WIDTH-1:0] mdrValue,
   output isaPkg::instr_t         irValue,
   output logic                   aluFinished
);

   logic [`WORD_WIDTH-1:0]   bus;
   logic [`WORD_WIDTH-1:0]   rfData;
   logic [`WORD_WIDTH-1:0]   yReg;
   logic [`WORD_WIDTH-1:0]   hiReg;
   logic [`WORD_WIDTH-1:0]   mdrReg;
   logic [2*`WORD_WIDTH-1:0] zReg;
   logic [2*`WORD_WIDTH-1:0] aluResult;
   isaPkg::instr_t           irReg;

   registerFile #(.DEPTH(`REG_COUNT), .SEL_WIDTH(`REG_SEL_WIDTH)) regFile (
      .Clock       (Clock),
      .reset       (reset),
      .select      (ctrl.rfSelect),
      .writeEnable (ctrl.rfIn),
      .writeData   (bus),
      .readData    (rfData)
   );

   alu aluUnit (
      .Clock    (Clock),
      .reset    (reset),
      .op       (ctrl.aluOp),
      .a        (yReg),
      .b        (bus),
      .start    (ctrl.aluStart),
      .result   (aluResult),
      .finished (aluFinished)
   );

   // single shared bus, one driver per cycle
   always_comb begin
      case (ctrl.busSource)
         busPkg::SRC_RF:     bus = rfData;
         busPkg::SRC_MDR:    bus = mdrReg;
         busPkg::SRC_ZLO:    bus = zReg[`WORD_WIDTH-1:0];
         busPkg::SRC_ZHI:    bus = zReg[2*`WORD_WIDTH-1:`WORD_WIDTH];
         busPkg::SRC_HI:     bus = hiReg;
         busPkg::SRC_DATAIN: bus = dataIn;
         default:            bus = '0;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         yReg   <= '0;
         zReg   <= '0;
         hiReg  <= '0;
         mdrReg <= '0;
         irReg  <= '0;
      end else begin
         if (ctrl.yIn)
            yReg <= bus;
         if (ctrl.zIn)
            zReg <= aluResult;
         if (ctrl.hiIn)
            hiReg <= bus;
         if (ctrl.mdrIn)
            mdrReg <= bus;
         if (ctrl.irIn)
            irReg <= instr;   // decode runs from IR from T1 on
      end
   end

   assign mdrValue = mdrReg;
   assign irValue  = irReg;

endmodule

// ==== busPkg.sv ====
`include "datapath_consts.svh"

package busPkg;

   // which block drives the shared bus this cycle
   typedef enum logic [2:0] {
      SRC_NONE,
      SRC_RF,
      SRC_MDR,
      SRC_ZLO,
      SRC_ZHI,
      SRC_HI,
      SRC_DATAIN
   } busSource_e;

   typedef struct packed {
      busSource_e                busSource;
      logic [`REG_SEL_WIDTH-1:0] rfSelect;
      logic                      rfIn;
      logic                      yIn;
      logic                      zIn;    // loads all 64 bits of Z
      logic                      hiIn;
      logic                      mdrIn;
      logic                      irIn;
      isaPkg::aluOp_e            aluOp;
      logic                      aluStart;
   } controlWord_t;

endpackage

// ==== controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer (
   input  logic                 Clock,
   input  logic                 reset,
   input  logic                 go,
   input  isaPkg::instr_t       instr,
   input  logic                 aluFinished,
   output busPkg::controlWord_t ctrl,
   output logic                 busy,
   output logic                 done
);

   isaPkg::seqState_e state;
   isaPkg::seqState_e nextState;
   logic              mulRunning;   // start sent, waiting on finished
   logic              isMul;

   assign isMul = instr.opcode == isaPkg::OP_MUL;
   assign busy  = state != isaPkg::IDLE;

   function automatic isaPkg::aluOp_e aluOpFor(isaPkg::opcode_e opcode);
      case (opcode)
         isaPkg::OP_SUB: return isaPkg::ALU_SUB;
         isaPkg::OP_AND: return isaPkg::ALU_AND;
         isaPkg::OP_OR:  return isaPkg::ALU_OR;
         isaPkg::OP_NOT: return isaPkg::ALU_NOT;
         isaPkg::OP_NEG: return isaPkg::ALU_NEG;
         isaPkg::OP_MUL: return isaPkg::ALU_MUL;
         default:        return isaPkg::ALU_ADD;
      endcase
   endfunction

   always_ff @(posedge Clock) begin
      if (reset) begin
         state      <= isaPkg::IDLE;
         mulRunning <= 1'b0;
      end else begin
         state <= nextState;
         if (ctrl.aluStart)
            mulRunning <= 1'b1;
         else if (aluFinished)
            mulRunning <= 1'b0;
      end
   end

   always_comb begin
      ctrl      = '0;
      nextState = state;
      done      = 1'b0;
      case (state)
         isaPkg::IDLE: begin
            if (go)
               nextState = isaPkg::T0;
         end
         isaPkg::T0: begin
            ctrl.irIn = 1'b1;
            nextState = isaPkg::T1;
         end
         isaPkg::T1: begin
            case (instr.opcode)
               isaPkg::OP_LOAD: begin
                  ctrl.busSource = busPkg::SRC_DATAIN;
                  ctrl.mdrIn     = 1'b1;
                  nextState      = isaPkg::T2;
               end
               isaPkg::OP_READ: begin
                  ctrl.busSource = busPkg::SRC_RF;
                  ctrl.rfSelect  = instr.rs;
                  ctrl.mdrIn     = 1'b1;
                  done           = 1'b1;
                  nextState      = isaPkg::IDLE;
               end
               isaPkg::OP_MFHI: begin
                  ctrl.busSource = busPkg::SRC_HI;
                  ctrl.rfSelect  = instr.rd;
                  ctrl.rfIn      = 1'b1;
                  done           = 1'b1;
                  nextState      = isaPkg::IDLE;
               end
               default: begin   // alu ops, first operand into Y
                  ctrl.busSource = busPkg::SRC_RF;
                  ctrl.rfSelect  = instr.rs;
                  ctrl.yIn       = 1'b1;
                  nextState      = isaPkg::T2;
               end
            endcase
         end
         isaPkg::T2: begin
            if (instr.opcode == isaPkg::OP_LOAD) begin
               ctrl.busSource = busPkg::SRC_MDR;
               ctrl.rfSelect  = instr.rd;
               ctrl.rfIn      = 1'b1;
               done           = 1'b1;
               nextState      = isaPkg::IDLE;
            end else begin
               ctrl.busSource = busPkg::SRC_RF;
               ctrl.rfSelect  = instr.rt;
               ctrl.aluOp     = aluOpFor(instr.opcode);
               if (isMul) begin
                  ctrl.aluStart = !mulRunning;   // single-cycle start
                  ctrl.zIn      = aluFinished;
                  if (aluFinished)
                     nextState = isaPkg::T3;
               end else begin
                  ctrl.zIn  = 1'b1;
                  nextState = isaPkg::T3;
               end
            end
         end
         isaPkg::T3: begin
            ctrl.busSource = busPkg::SRC_ZLO;
            ctrl.rfSelect  = instr.rd;
            ctrl.rfIn      = 1'b1;
            if (isMul) begin
               nextState = isaPkg::T4;
            end else begin
               done      = 1'b1;
               nextState = isaPkg::IDLE;
            end
         end
         isaPkg::T4: begin
            ctrl.busSource = busPkg::SRC_ZHI;   // upper product word into HI
            ctrl.hiIn      = 1'b1;
            done           = 1'b1;
            nextState      = isaPkg::IDLE;
         end
         default: nextState = isaPkg::IDLE;
      endcase
   end

endmodule

// ==== cpuCore.f ====
+incdir+.
isaPkg.sv
busPkg.sv
registerFile.sv
alu.sv
busDatapath.sv
hostRegs.sv
controlSequencer.sv
cpuCore.sv
tbCpuCore.sv

// ==== cpuCore.sv ====
`timescale 1ns/1ps
`include "datapath_consts.svh"

module cpuCore (
   input  logic                       Clock,
   input  logic                       reset,
   input  logic [`AXI_ADDR_WIDTH-1:0] awAddr,
   input  logic                       awValid,
   output logic                       awReady,
   input  logic [`WORD_WIDTH-1:0]     wData,
   input  logic [`WORD_WIDTH/8-1:0]   wStrb,
   input  logic                       wValid,
   output logic                       wReady,
   output logic [1:0]                 bResp,
   output logic                       bValid,
   input  logic                       bReady,
   input  logic [`AXI_ADDR_WIDTH-1:0] arAddr,
   input  logic                       arValid,
   output logic                       arReady,
   output logic [`WORD_WIDTH-1:0]     rData,
   output logic [1:0]                 rResp,
   output logic                       rValid,
   input  logic                       rReady
);

   logic                   go;
   logic                   busy;
   logic                   done;
   logic                   aluFinished;
   logic [`WORD_WIDTH-1:0] dataIn;
   logic [`WORD_WIDTH-1:0] mdrValue;
   isaPkg::instr_t         instr;
   isaPkg::instr_t         irValue;
   busPkg::controlWord_t   ctrl;

   hostRegs host (
      .Clock    (Clock),
      .reset    (reset),
      .awAddr   (awAddr),
      .awValid  (awValid),
      .awReady  (awReady),
      .wData    (wData),
      .wStrb    (wStrb),
      .wValid   (wValid),
      .wReady   (wReady),
      .bResp    (bResp),
      .bValid   (bValid),
      .bReady   (bReady),
      .arAddr   (arAddr),
      .arValid  (arValid),
      .arReady  (arReady),
      .rData    (rData),
      .rResp    (rResp),
      .rValid   (rValid),
      .rReady   (rReady),
      .busy     (busy),
      .done     (done),
      .mdrValue (mdrValue),
      .go       (go),
      .instr    (instr),
      .dataIn   (dataIn)
   );

   controlSequencer sequencer (
      .Clock       (Clock),
      .reset       (reset),
      .go          (go),
      .instr       (irValue),   // decodes from the latched IR
      .aluFinished (aluFinished),
      .ctrl        (ctrl),
      .busy        (busy),
      .done        (done)
   );

   busDatapath datapath (
      .Clock       (Clock),
      .reset       (reset),
      .ctrl        (ctrl),
      .dataIn      (dataIn),
      .instr       (instr),
      .mdrValue    (mdrValue),
      .irValue     (irValue),
      .aluFinished (aluFinished)
   );

endmodule

// ==== datapath_consts.svh ====
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

`define WORD_WIDTH     32
`define REG_COUNT      16
`define REG_SEL_WIDTH  4
`define MUL_CYCLES     32   // one shift-add step per multiplier bit

// axi4-lite register map, word aligned
`define AXI_ADDR_WIDTH 4
`define ADDR_INSTR     4'h0
`define ADDR_DATAIN    4'h4
`define ADDR_STATUS    4'h8
`define ADDR_RESULT    4'hC

`define RESP_OKAY      2'b00
`define RESP_SLVERR    2'b10

`endif

// ==== hostRegs.sv ====
`timescale 1ns/1ps
`include "datapath_consts.svh"

module hostRegs (
   input  logic                       Clock,
   input  logic                       reset,
   input  logic [`AXI_ADDR_WIDTH-1:0] awAddr,
   input  logic                       awValid,
   output logic                       awReady,
   input  logic [`WORD_WIDTH-1:0]     wData,
   input  logic [`WORD_WIDTH/8-1:0]   wStrb,
   input  logic                       wValid,
   output logic                       wReady,
   output logic [1:0]                 bResp,
   output logic                       bValid,
   input  logic                       bReady,
   input  logic [`AXI_ADDR_WIDTH-1:0] arAddr,
   input  logic                       arValid,
   output logic                       arReady,
   output logic [`WORD_WIDTH-1:0]     rData,
   output logic [1:0]                 rResp,
   output logic                       rValid,
   input  logic                       rReady,
   input  logic                       busy,
   input  logic                       done,
   input  logic [`WORD_WIDTH-1:0]     mdrValue,
   output logic                       go,
   output isaPkg::instr_t             instr,
   output logic [`WORD_WIDTH-1:0]     dataIn
);

   logic                   writeFire;
   logic                   readFire;
   logic                   coreBusy;
   logic                   doneFlag;   // sticky until next accepted start
   logic [`WORD_WIDTH-1:0] readMux;

   // a pending response holds off the next request of that direction
   assign awReady   = !bValid;
   assign wReady    = !bValid;
   assign arReady   = !rValid;
   assign writeFire = awValid && wValid && !bValid;
   assign readFire  = arValid && !rValid;
   assign coreBusy  = busy || go;   // go is still in flight for one cycle

   always_ff @(posedge Clock) begin
      if (reset) begin
         bValid   <= 1'b0;
         bResp    <= `RESP_OKAY;
         go       <= 1'b0;
         doneFlag <= 1'b0;
         instr    <= '0;
         dataIn   <= '0;
      end else begin
         go <= 1'b0;
         if (done)
            doneFlag <= 1'b1;
         if (writeFire) begin
            bValid <= 1'b1;
            bResp  <= `RESP_OKAY;
            case (awAddr)
               `ADDR_INSTR: begin
                  if (coreBusy) begin
                     bResp <= `RESP_SLVERR;   // start refused, word dropped
                  end else begin
                     instr    <= isaPkg::instr_t'(wData);
                     go       <= 1'b1;
                     doneFlag <= 1'b0;
                  end
               end
               `ADDR_DATAIN: begin
                  for (int i = 0; i < `WORD_WIDTH/8; i++) begin
                     if (wStrb[i])
                        dataIn[8*i +: 8] <= wData[8*i +: 8];
                  end
               end
               default: ;   // status and result are read only
            endcase
         end else if (bValid && bReady) begin
            bValid <= 1'b0;
         end
      end
   end

   always_comb begin
      case (arAddr)
         `ADDR_DATAIN: readMux = dataIn;
         `ADDR_STATUS: readMux = {{(`WORD_WIDTH-2){1'b0}}, doneFlag, coreBusy};
         `ADDR_RESULT: readMux = mdrValue;
         default:      readMux = '0;   // instr reads back as zero
      endcase
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         rValid <= 1'b0;
         rResp  <= `RESP_OKAY;
         rData  <= '0;
      end else if (readFire) begin
         rValid <= 1'b1;
         rResp  <= `RESP_OKAY;
         rData  <= readMux;
      end else if (rValid && rReady) begin
         rValid <= 1'b0;
      end
   end

endmodule

// ==== isaPkg.sv ====
`include "datapath_consts.svh"

package isaPkg;

   typedef enum logic [4:0] {
      OP_LOAD = 5'b00000,
      OP_READ = 5'b00001,
      OP_ADD  = 5'b00011,
      OP_SUB  = 5'b00100,
      OP_AND  = 5'b00101,
      OP_OR   = 5'b00110,
      OP_MUL  = 5'b01110,
      OP_NEG  = 5'b10000,
      OP_NOT  = 5'b10001,
      OP_MFHI = 5'b11000
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_NOT,
      ALU_NEG,
      ALU_MUL
   } aluOp_e;

   typedef struct packed {
      opcode_e                                    opcode;  // bits 31:27
      logic [`REG_SEL_WIDTH-1:0]                  rd;
      logic [`REG_SEL_WIDTH-1:0]                  rs;
      logic [`REG_SEL_WIDTH-1:0]                  rt;
      logic [`WORD_WIDTH-5-3*`REG_SEL_WIDTH-1:0]  spare;
   } instr_t;

   typedef enum logic [2:0] {IDLE, T0, T1, T2, T3, T4} seqState_e;

endpackage

// ==== registerFile.sv ====
`timescale 1ns/1ps
`include "datapath_consts.svh"

module registerFile #(
   parameter int DEPTH     = `REG_COUNT,
   parameter int SEL_WIDTH = `REG_SEL_WIDTH
) (
   input  logic                   Clock,
   input  logic                   reset,
   input  logic [SEL_WIDTH-1:0]   select,
   input  logic                   writeEnable,
   input  logic [`WORD_WIDTH-1:0] writeData,
   output logic [`WORD_WIDTH-1:0] readData
);

   logic [`WORD_WIDTH-1:0] regs [DEPTH];

   assign readData = regs[select];   // async read, same select as the write

   always_ff @(posedge Clock) begin
      if (reset) begin
         for (int i = 0; i < DEPTH; i++)
            regs[i] <= '0;
      end else if (writeEnable) begin
         regs[select] <= writeData;
      end
   end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# build the cpuCore testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f cpuCore.f --top-module tbCpuCore -o simCpuCore
./obj_dir/simCpuCore | tee sim.log

if grep -q "Finished with no errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== tbCpuCore.sv ====
`timescale 1ns/1ps
`include "datapath_consts.svh"

module tbCpuCore;

   localparam int InstrRuns     = 53;    // instructions issued by all tests together
   localparam int CyclesPerRun  = 200;
   localparam int MulRuns       = 3;
   localparam int TimeoutCycles = InstrRuns * CyclesPerRun + MulRuns * `MUL_CYCLES;

   logic                       Clock;
   logic                       reset;
   logic [`AXI_ADDR_WIDTH-1:0] awAddr;
   logic                       awValid;
   logic                       awReady;
   logic [`WORD_WIDTH-1:0]     wData;
   logic [`WORD_WIDTH/8-1:0]   wStrb;
   logic                       wValid;
   logic                       wReady;
   logic [1:0]                 bResp;
   logic                       bValid;
   logic                       bReady;
   logic [`AXI_ADDR_WIDTH-1:0] arAddr;
   logic                       arValid;
   logic                       arReady;
   logic [`WORD_WIDTH-1:0]     rData;
   logic [1:0]                 rResp;
   logic                       rValid;
   logic                       rReady;

   cpuCore UUT (.*);

   initial begin
      Clock = 1'b0;
      forever #5 Clock = ~Clock;
   end

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s, got 0x%08h, expected 0x%08h",
                  $time, what, actual, expected);
         $display("Finished with errors");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic axiWrite(input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           input int holdCycles, output logic [1:0] resp);
      @(negedge Clock);
      awAddr  = addr;
      awValid = 1'b1;
      wData   = data;
      wStrb   = '1;
      wValid  = 1'b1;
      while (!(awReady && wReady))   // readies only move on a rising edge
         @(negedge Clock);
      @(negedge Clock);
      awValid = 1'b0;
      wValid  = 1'b0;
      while (!bValid)
         @(negedge Clock);
      repeat (holdCycles) begin
         @(negedge Clock);
         checkValue({31'b0, bValid}, 32'd1, "write response lost while bReady low");
      end
      resp   = bResp;
      bReady = 1'b1;
      @(negedge Clock);
      bReady = 1'b0;
   endtask

   task automatic axiRead(input logic [`AXI_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
      @(negedge Clock);
      arAddr  = addr;
      arValid = 1'b1;
      while (!arReady)
         @(negedge Clock);
      @(negedge Clock);
      arValid = 1'b0;
      rReady  = 1'b1;
      while (!rValid)
         @(negedge Clock);
      data = rData;
      checkValue({30'b0, rResp}, {30'b0, `RESP_OKAY}, "read response");
      @(negedge Clock);
      rReady = 1'b0;
   endtask

   // poll status until the sticky done bit shows up
   task automatic waitDone(output logic [31:0] status);
      status = '0;
      while (!status[1])
         axiRead(`ADDR_STATUS, status);
   endtask

   task automatic runInstr(input isaPkg::opcode_e op, input logic [3:0] rd,
                           input logic [3:0] rs, input logic [3:0] rt);
      logic [1:0]  resp;
      logic [31:0] status;
      axiWrite(`ADDR_INSTR, {op, rd, rs, rt, 15'b0}, 0, resp);
      checkValue({30'b0, resp}, {30'b0, `RESP_OKAY}, "instruction write response");
      waitDone(status);
      checkValue({31'b0, status[0]}, 32'd0, "busy after done");
   endtask

   task automatic loadReg(input logic [3:0] regNum, input logic [31:0] value);
      logic [1:0] resp;
      axiWrite(`ADDR_DATAIN, value, 0, resp);
      checkValue({30'b0, resp}, {30'b0, `RESP_OKAY}, "DATAIN write response");
      runInstr(isaPkg::OP_LOAD, regNum, 4'd0, 4'd0);
   endtask

   task automatic readReg(input logic [3:0] regNum, output logic [31:0] value);
      runInstr(isaPkg::OP_READ, 4'd0, regNum, 4'd0);
      axiRead(`ADDR_RESULT, value);
   endtask

   task automatic testLoadRead();
      logic [3:0]  regList [3];
      logic [31:0] value;
      logic [31:0] got;
      regList = '{4'd0, 4'd7, 4'd15};
      for (int i = 0; i < 8; i++) begin
         value = $urandom;
         loadReg(regList[i % 3], value);
         readReg(regList[i % 3], got);
         checkValue(got, value, $sformatf("LOAD then READ on R%0d", regList[i % 3]));
      end
   endtask

   task automatic testNegNot();
      logic [31:0] got;
      loadReg(4'd7, 32'h12);
      runInstr(isaPkg::OP_NEG, 4'd6, 4'd7, 4'd15);   // rt carries junk, must be ignored
      readReg(4'd6, got);
      checkValue(got, ~32'h12 + 32'd1, "NEG R6, R7");
      runInstr(isaPkg::OP_NOT, 4'd5, 4'd7, 4'd15);
      readReg(4'd5, got);
      checkValue(got, ~32'h12, "NOT R5, R7");
   endtask

   task automatic testAluOps();
      isaPkg::opcode_e ops [4];
      logic [31:0]     a;
      logic [31:0]     b;
      logic [31:0]     expected;
      logic [31:0]     got;
      ops = '{isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND, isaPkg::OP_OR};
      for (int i = 0; i < 4; i++) begin
         a = $urandom;
         b = $urandom;
         case (i)
            0:       expected = a + b;
            1:       expected = a - b;
            2:       expected = a & b;
            default: expected = a | b;
         endcase
         loadReg(4'd1, a);
         loadReg(4'd2, b);
         runInstr(ops[i], 4'(3 + i), 4'd1, 4'd2);
         readReg(4'(3 + i), got);
         checkValue(got, expected, $sformatf("%s on 0x%08h, 0x%08h", ops[i].name(), a, b));
      end
   endtask

   task automatic testMul();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] got;
      logic [63:0] product;
      for (int i = 0; i < 2; i++) begin
         a       = $urandom;
         b       = $urandom;
         product = {32'b0, a} * {32'b0, b};
         loadReg(4'd1, a);
         loadReg(4'd2, b);
         runInstr(isaPkg::OP_MUL, 4'd9, 4'd1, 4'd2);
         readReg(4'd9, got);
         checkValue(got, product[31:0], "MUL low word");
         runInstr(isaPkg::OP_MFHI, 4'd10, 4'd0, 4'd0);
         readReg(4'd10, got);
         checkValue(got, product[63:32], "MFHI high word");
      end
   endtask

   task automatic testHandshake();
      logic [1:0]  resp;
      logic [31:0] status;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] got;
      logic [63:0] product;
      a       = $urandom;
      b       = $urandom;
      product = {32'b0, a} * {32'b0, b};
      loadReg(4'd1, a);
      loadReg(4'd2, b);
      axiWrite(`ADDR_INSTR, {isaPkg::OP_MUL, 4'd11, 4'd1, 4'd2, 15'b0}, 0, resp);
      checkValue({30'b0, resp}, {30'b0, `RESP_OKAY}, "MUL start response");
      axiRead(`ADDR_STATUS, status);
      checkValue({30'b0, status[1:0]}, 32'd1, "STATUS while MUL runs");
      // second start while busy must bounce
      axiWrite(`ADDR_INSTR, {isaPkg::OP_LOAD, 4'd11, 4'd0, 4'd0, 15'b0}, 0, resp);
      checkValue({30'b0, resp}, {30'b0, `RESP_SLVERR}, "INSTR write during MUL");
      waitDone(status);
      axiRead(`ADDR_STATUS, status);
      checkValue({30'b0, status[1:0]}, 32'd2, "STATUS after MUL");
      readReg(4'd11, got);
      checkValue(got, product[31:0], "MUL result after refused start");
      a = $urandom;
      axiWrite(`ADDR_DATAIN, a, 6, resp);   // bReady held low for 6 cycles
      checkValue({30'b0, resp}, {30'b0, `RESP_OKAY}, "delayed write response");
      axiRead(`ADDR_DATAIN, got);
      checkValue(got, a, "DATAIN after delayed response");
   endtask

   initial begin
      void'($urandom(32'hb3b8));
      reset     = 1'b1;
      awAddr    = '0;
      awValid   = 1'b0;
      wData     = '0;
      wStrb     = '0;
      wValid    = 1'b0;
      bReady    = 1'b0;
      arAddr    = '0;
      arValid   = 1'b0;
      rReady    = 1'b0;
      repeat (3) @(posedge Clock);
      @(negedge Clock);
      reset = 1'b0;
      checkValue({29'b0, awReady, wReady, arReady}, 32'd7, "readies after reset");
      checkValue({30'b0, bValid, rValid}, 32'd0, "response valids after reset");

      testLoadRead();
      testNegNot();
      testAluOps();
      testMul();
      testHandshake();

      $display("Finished with no errors");
      $finish;
   end

   // watchdog
   initial begin
      repeat (TimeoutCycles) @(posedge Clock);
      $display("Timeout: tests still running after %0d clock cycles", TimeoutCycles);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

endmodule
